/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = int_exec_unit_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/alu_core.sv */
/*
 * integer ALU, computes one decoded operation on operands a and b
 */

`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  alu_pkg::exec_item_t item,
    output alu_pkg::xlen_t      result
);

    import alu_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // register or immediate shift amount, low bits only
    assign shamt = item.b[SHAMT_W-1:0];

    assign lt_signed   = $signed(item.a) < $signed(item.b);
    assign lt_unsigned = item.a < item.b;

    always_comb begin
        case (item.op)
            ALU_ADD: begin
                result = item.a + item.b;
            end
            ALU_SUB: begin
                result = item.a - item.b;
            end
            ALU_SLL: begin
                result = item.a << shamt;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                result = item.a ^ item.b;
            end
            ALU_SRL: begin
                result = item.a >> shamt;
            end
            ALU_SRA: begin
                result = xlen_t'($signed(item.a) >>> shamt);
            end
            ALU_OR: begin
                result = item.a | item.b;
            end
            ALU_AND: begin
                result = item.a & item.b;
            end
            default: begin
                // nop and unknown opcodes
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
/*
 * integer execute unit shared definitions
 * widths, instruction encodings, operation codes and pipeline items
 */

`default_nettype none

package alu_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    // major opcodes
    localparam logic [6:0] OPCODE_R_ARITH = 7'b0110011;
    localparam logic [6:0] OPCODE_I_ARITH = 7'b0010011;

    // funct3 codes, shared by register and immediate forms
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    // instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_W   = 3;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_W   = 7;
    localparam int IMM12_LSB  = 20;
    localparam int IMM12_W    = 12;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        logic      use_imm;
        logic      rd_wr;
    } dec_inst_t;

    // execute stage contents, operands already resolved
    typedef struct packed {
        alu_op_e   op;
        reg_addr_t rd;
        logic      rd_wr;
        xlen_t     a;
        xlen_t     b;
    } exec_item_t;

    typedef struct packed {
        logic      rd_wr;
        reg_addr_t rd;
        xlen_t     val;
    } wb_item_t;

endpackage

`default_nettype wire

/* hdl/inst_decoder.sv */
/*
 * instruction decoder
 * splits an RV32I arithmetic instruction into fields and picks the ALU operation
 */

`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  alu_pkg::inst_t     instr,
    output alu_pkg::dec_inst_t dec
);

    import alu_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic [IMM12_W-1:0]  imm12;
    logic                is_r;
    logic                is_i;

    assign opcode = instr[OPCODE_LSB +: OPCODE_W];
    assign funct3 = instr[FUNCT3_LSB +: FUNCT3_W];
    assign funct7 = instr[FUNCT7_LSB +: FUNCT7_W];
    assign imm12  = instr[IMM12_LSB +: IMM12_W];

    assign is_r = (opcode == OPCODE_R_ARITH);
    assign is_i = (opcode == OPCODE_I_ARITH);

    always_comb begin
        dec.rd      = instr[RD_LSB +: REG_ADDR_W];
        dec.rs1     = instr[RS1_LSB +: REG_ADDR_W];
        dec.rs2     = instr[RS2_LSB +: REG_ADDR_W];
        dec.imm     = {{(XLEN-IMM12_W){imm12[IMM12_W-1]}}, imm12};
        dec.use_imm = is_i;
        dec.rd_wr   = is_r | is_i;
        dec.op      = ALU_NOP;

        if (is_r || is_i) begin
            case (funct3)
                // no SUBI, immediate bit 5 of funct7 is just imm data
                FUNCT3_ADD:  dec.op = (is_r && funct7[5]) ? ALU_SUB : ALU_ADD;
                FUNCT3_SLL:  dec.op = ALU_SLL;
                FUNCT3_SLT:  dec.op = ALU_SLT;
                FUNCT3_SLTU: dec.op = ALU_SLTU;
                FUNCT3_XOR:  dec.op = ALU_XOR;
                FUNCT3_SR:   dec.op = funct7[5] ? ALU_SRA : ALU_SRL;
                FUNCT3_OR:   dec.op = ALU_OR;
                FUNCT3_AND:  dec.op = ALU_AND;
                default:     dec.op = ALU_NOP;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/int_exec_unit.sv */
/*
 * two-stage RV32I integer execute unit
 * decode, operand forwarding, ALU and writeback with back-pressure
 */

`timescale 1ns/1ps
`default_nettype none

module int_exec_unit (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              alu_en,
    output logic              alu_ready,
    output logic              alu_empty,
    input  alu_pkg::inst_t    alu_instbus,
    output logic              wb_valid,
    input  logic              wb_ready,
    output alu_pkg::wb_item_t wb
);

    import alu_pkg::*;

    dec_inst_t  dec;
    xlen_t      rf_rs1_val;
    xlen_t      rf_rs2_val;
    xlen_t      src_a;
    xlen_t      src_b;
    logic       exec_valid;
    exec_item_t exec_item;
    xlen_t      exec_result;
    logic       rf_wr_en;

    inst_decoder inst_decoder_i (
        .instr (alu_instbus),
        .dec   (dec)
    );

    reg_file reg_file_i (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_val (rf_rs1_val),
        .rs2_val (rf_rs2_val),
        .wr_en   (rf_wr_en),
        .wr_addr (wb.rd),
        .wr_val  (wb.val)
    );

    operand_bypass operand_bypass_i (
        .dec         (dec),
        .exec_valid  (exec_valid),
        .exec_item   (exec_item),
        .exec_result (exec_result),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .rf_rs1_val  (rf_rs1_val),
        .rf_rs2_val  (rf_rs2_val),
        .src_a       (src_a),
        .src_b       (src_b)
    );

    alu_core alu_core_i (
        .item   (exec_item),
        .result (exec_result)
    );

    pipe_ctrl pipe_ctrl_i (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .alu_en      (alu_en),
        .alu_ready   (alu_ready),
        .alu_empty   (alu_empty),
        .dec         (dec),
        .src_a       (src_a),
        .src_b       (src_b),
        .exec_valid  (exec_valid),
        .exec_item   (exec_item),
        .exec_result (exec_result),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb          (wb),
        .rf_wr_en    (rf_wr_en)
    );

endmodule

`default_nettype wire

/* hdl/operand_bypass.sv */
/*
 * operand forwarding
 * picks each source from the execute stage, the writeback stage or the register file
 */

`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  alu_pkg::dec_inst_t  dec,
    input  logic                exec_valid,
    input  alu_pkg::exec_item_t exec_item,
    input  alu_pkg::xlen_t      exec_result,
    input  logic                wb_valid,
    input  alu_pkg::wb_item_t   wb,
    input  alu_pkg::xlen_t      rf_rs1_val,
    input  alu_pkg::xlen_t      rf_rs2_val,
    output alu_pkg::xlen_t      src_a,
    output alu_pkg::xlen_t      src_b
);

    import alu_pkg::*;

    // youngest producer wins
    function automatic xlen_t fwd(input reg_addr_t rs, input xlen_t rf_val);
        logic exec_hit;
        logic wb_hit;
        exec_hit = exec_valid && exec_item.rd_wr && (exec_item.rd == rs);
        wb_hit   = wb_valid && wb.rd_wr && (wb.rd == rs);
        if (rs == '0) begin
            return rf_val;
        end else if (exec_hit) begin
            return exec_result;
        end else if (wb_hit) begin
            return wb.val;
        end
        return rf_val;
    endfunction

    always_comb begin
        src_a = fwd(dec.rs1, rf_rs1_val);
        src_b = fwd(dec.rs2, rf_rs2_val);
    end

endmodule

`default_nettype wire

/* hdl/pipe_ctrl.sv */
/*
 * pipeline control
 * execute and writeback stage registers with valid/ready flow control
 */

`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                alu_en,
    output logic                alu_ready,
    output logic                alu_empty,
    input  alu_pkg::dec_inst_t  dec,
    input  alu_pkg::xlen_t      src_a,
    input  alu_pkg::xlen_t      src_b,
    output logic                exec_valid,
    output alu_pkg::exec_item_t exec_item,
    input  alu_pkg::xlen_t      exec_result,
    output logic                wb_valid,
    input  logic                wb_ready,
    output alu_pkg::wb_item_t   wb,
    output logic                rf_wr_en
);

    import alu_pkg::*;

    logic wb_fire;
    logic advance;
    logic accept;

    //////////////////////////////////////////////////////////////////////
    // flow control
    //////////////////////////////////////////////////////////////////////

    assign wb_fire   = wb_valid & wb_ready;
    assign advance   = exec_valid & (~wb_valid | wb_fire);
    assign alu_ready = ~exec_valid | advance;
    assign accept    = alu_en & alu_ready;
    assign alu_empty = ~exec_valid & ~wb_valid;

    // commit happens on the writeback handshake
    assign rf_wr_en = wb_fire & wb.rd_wr;

    //////////////////////////////////////////////////////////////////////
    // stage valid bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            exec_valid <= 1'b0;
        end else if (accept) begin
            exec_valid <= 1'b1;
        end else if (advance) begin
            exec_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (advance) begin
            wb_valid <= 1'b1;
        end else if (wb_fire) begin
            wb_valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (accept) begin
            exec_item.op    <= dec.op;
            exec_item.rd    <= dec.rd;
            exec_item.rd_wr <= dec.rd_wr;
            exec_item.a     <= src_a;
            exec_item.b     <= dec.use_imm ? dec.imm : src_b;
        end
    end

    // held while the consumer stalls
    always_ff @(posedge aclk) begin
        if (advance) begin
            wb.rd_wr <= exec_item.rd_wr;
            wb.rd    <= exec_item.rd;
            wb.val   <= exec_item.rd_wr ? exec_result : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
/*
 * integer register file, 2 read ports and 1 write port, x0 hardwired to zero
 */

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                aclk,
    input  logic                rst_n,
    input  alu_pkg::reg_addr_t  rs1,
    input  alu_pkg::reg_addr_t  rs2,
    output alu_pkg::xlen_t      rs1_val,
    output alu_pkg::xlen_t      rs2_val,
    input  logic                wr_en,
    input  alu_pkg::reg_addr_t  wr_addr,
    input  alu_pkg::xlen_t      wr_val
);

    import alu_pkg::*;

    // x1..x31 only
    xlen_t regs [1:NUM_REGS-1];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_val;
        end
    end

    // plain reads, same-cycle writes come through the bypass
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* sources.f */
+incdir+testbench
hdl/alu_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/alu_core.sv
hdl/pipe_ctrl.sv
hdl/int_exec_unit.sv
testbench/int_exec_unit_tb.sv

/* testbench/ref_model.svh */
/*
 * register model for the execute unit testbench
 * computes expected writeback items in issue order
 */

`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

xlen_t    model_regs [0:NUM_REGS-1];
wb_item_t exp_q [$];

// expected item from the model state at issue, then commit
function automatic wb_item_t model_issue(input inst_t ins);
    wb_item_t   it;
    xlen_t      a;
    xlen_t      b;
    logic       is_r;
    logic [4:0] sh;
    is_r     = (ins[6:0] == OPCODE_R_ARITH);
    a        = model_regs[ins[19:15]];
    b        = is_r ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    sh       = b[4:0];
    it.rd    = ins[11:7];
    it.rd_wr = is_r || (ins[6:0] == OPCODE_I_ARITH);
    it.val   = '0;
    if (it.rd_wr) begin
        case (ins[14:12])
            3'd0: it.val = (is_r && ins[30]) ? a - b : a + b;
            3'd1: it.val = a << sh;
            3'd2: it.val = {31'b0, $signed(a) < $signed(b)};
            3'd3: it.val = {31'b0, a < b};
            3'd4: it.val = a ^ b;
            // bit 30 picks the arithmetic shift in both forms
            3'd5: it.val = ins[30] ? xlen_t'($signed(a) >>> sh) : a >> sh;
            3'd6: it.val = a | b;
            default: it.val = a & b;
        endcase
        if (it.rd != 0) begin
            model_regs[it.rd] = it.val;
        end
    end
    return it;
endfunction

`endif

/* testbench/int_exec_unit_tb.sv */
/*
 * testbench for the integer execute unit
 * random RV32I arithmetic checked against a register model
 */

`timescale 1ns/1ps
`default_nettype none

module int_exec_unit_tb;

    import alu_pkg::*;

    localparam int TIMEOUT = 200;

    logic     aclk;
    logic     rst_n;
    logic     alu_en;
    logic     alu_ready;
    logic     alu_empty;
    inst_t    alu_instbus;
    logic     wb_valid;
    logic     wb_ready;
    wb_item_t wb;

    integer   seed;
    logic     stall_mode;
    int       errors;
    int       pass_cnt;
    int       fail_cnt;
    int       ready_low_cnt;
    wb_item_t exp_item;

    `include "ref_model.svh"

    int_exec_unit int_exec_unit_i (.*);

    always #4 aclk = ~aclk;

    always @(posedge aclk) begin
        wb_ready <= stall_mode ? (({$random(seed)} % 2) != 0) : 1'b1;
    end

    ////////////////////////////////////////////////////////////////////
    // handshake rules and scoreboard
    ////////////////////////////////////////////////////////////////////

    assert property (@(posedge aclk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb))
        else begin
            errors++;
            $display("%0t: wb item changed or dropped while stalled", $time);
        end

    // ready only drops with both stages full and stalled
    assert property (@(posedge aclk) disable iff (!rst_n)
        !alu_ready |-> wb_valid && !wb_ready)
        else begin
            errors++;
            $display("%0t: alu_ready low without a full stalled pipeline", $time);
        end

    // a pending result keeps the pipeline non-empty
    assert property (@(posedge aclk) disable iff (!rst_n)
        wb_valid |-> !alu_empty)
        else begin
            errors++;
            $display("%0t: alu_empty high while a result is pending", $time);
        end

    always @(negedge aclk) begin
        if (!alu_ready) begin
            ready_low_cnt++;
        end
        if (rst_n && wb_valid && wb_ready) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("%0t: wb item with no instruction outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                exp_item = exp_q.pop_front();
                // fields shown as rd/rd_wr/val
                assert (wb == exp_item) else begin
                    errors++;
                    $display("MISMATCH at %0t: got %0d/%b/%h, expected %0d/%b/%h", $time,
                             wb.rd, wb.rd_wr, wb.val, exp_item.rd, exp_item.rd_wr, exp_item.val);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    task automatic abort(input string what);
        $display("%0t: %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic issue(input inst_t ins);
        int waited;
        alu_en      <= 1'b1;
        alu_instbus <= ins;
        exp_q.push_back(model_issue(ins));
        waited = 0;
        @(negedge aclk);
        while (!alu_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort("instruction was never accepted");
            end
            @(negedge aclk);
        end
        @(posedge aclk);
    endtask

    task automatic drain();
        int waited;
        alu_en <= 1'b0;
        waited = 0;
        @(negedge aclk);
        while (!alu_empty || exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort("pipeline did not drain, results missing");
            end
            @(negedge aclk);
        end
        @(posedge aclk);
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors == mark) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED with %0d errors", name, errors - mark);
        end
    endtask

    function automatic inst_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPCODE_I_ARITH};
    endfunction

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'(1 + ({$random(seed)} % 15));
    endfunction

    function automatic inst_t rand_inst(input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
        logic [2:0] f3;
        logic       alt;
        f3  = 3'($random(seed));
        alt = 1'($random(seed));
        if (($random(seed) & 1) != 0) begin
            return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPCODE_R_ARITH};
        end
        return enc_i(f3, rd, rs1, 12'($random(seed)));
    endfunction

    ////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int          mark;
        int          sel;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        early;
        reg_addr_t   rd;
        reg_addr_t   prev1;
        reg_addr_t   prev2;
        seed          = 70;
        aclk          = 1'b0;
        rst_n         = 1'b0;
        alu_en        = 1'b0;
        alu_instbus   = '0;
        wb_ready      = 1'b1;
        stall_mode    = 1'b0;
        errors        = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        ready_low_cnt = 0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);

        mark = errors;
        @(negedge aclk);
        assert (alu_ready && alu_empty && !wb_valid) else begin
            errors++;
            $display("MISMATCH at %0t: after reset ready %b empty %b wb_valid %b", $time,
                     alu_ready, alu_empty, wb_valid);
        end
        @(posedge aclk);
        finish_test("reset", mark);

        // I-type one at a time so the latency shows
        mark = errors;
        for (int r = 1; r < 9; r++) begin
            issue(enc_i(3'd0, reg_addr_t'(r), 5'd0, 12'($random(seed))));
        end
        drain();
        for (int k = 0; k < 27; k++) begin
            sel = k % 9;
            imm = 12'($random(seed));
            if (sel == 5 || sel == 8) begin
                imm[10] = (sel == 8);
            end
            issue(enc_i((sel == 8) ? 3'd5 : 3'(sel), pick_reg(), pick_reg(), imm));
            alu_en <= 1'b0;
            @(negedge aclk);
            early = wb_valid;
            @(negedge aclk);
            assert (!early && wb_valid) else begin
                errors++;
                $display("%0t: result not valid exactly one edge after acceptance", $time);
            end
            @(posedge aclk);
        end
        finish_test("itype", mark);

        // all ten register forms with funct7 bit 5 for SUB and SRA
        mark = errors;
        for (int k = 0; k < 30; k++) begin
            sel = k % 10;
            f3  = (sel == 9) ? 3'd5 : (sel == 8) ? 3'd0 : 3'(sel);
            issue({1'b0, sel >= 8, 5'b0, pick_reg(), pick_reg(), f3, pick_reg(),
                   OPCODE_R_ARITH});
        end
        drain();
        finish_test("rtype", mark);

        mark  = errors;
        prev1 = pick_reg();
        prev2 = pick_reg();
        for (int k = 0; k < 24; k++) begin
            rd = pick_reg();
            issue(rand_inst(rd, prev1, prev2));
            prev2 = prev1;
            prev1 = rd;
        end
        drain();
        finish_test("dependent", mark);

        mark          = errors;
        ready_low_cnt = 0;
        stall_mode    <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            issue(rand_inst(pick_reg(), pick_reg(), pick_reg()));
        end
        drain();
        stall_mode <= 1'b0;
        assert (ready_low_cnt > 0) else begin
            errors++;
            $display("%0t: alu_ready never dropped under back-pressure", $time);
        end
        finish_test("backpressure", mark);

        // load opcode then x0 as destination and as source
        mark = errors;
        issue({25'($random(seed)), 7'b0000011});
        issue(enc_i(3'd0, 5'd0, 5'd1, 12'h7ff));
        issue({7'd0, 5'd0, 5'd0, 3'd0, 5'd9, OPCODE_R_ARITH});
        issue(enc_i(3'd6, 5'd10, 5'd0, 12'h055));
        drain();
        finish_test("opcode_x0", mark);

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
